// File: hdl/cache_bus_pkg.sv
/* shared sizes, bus encodings and flash region decode for the cache line port,
   plus the cache line union and the queued line request struct */
package cache_bus_pkg;

  // line and address geometry
  localparam int LINE_BITS   = 512;
  localparam int ADDR_BITS   = 64;
  localparam int FLASH_BEATS = 16;  // word beats per flash line
  localparam int FIFO_DEPTH  = 4;

  // top nibble of a 32-bit address that selects flash
  localparam logic [3:0] FLASH_REGION = 4'h3;

  // bus size codes
  localparam logic [2:0] SIZE_WORD  = 3'd2;
  localparam logic [2:0] SIZE_DWORD = 3'd3;

  // block counts, value is blocks minus one
  localparam logic [7:0] BLKS_BURST  = 8'd7;
  localparam logic [7:0] BLKS_SINGLE = 8'd0;

  // a line is read as one wide word or as word slices for flash
  typedef union packed {
    logic [LINE_BITS-1:0]                                raw;
    logic [FLASH_BEATS-1:0][LINE_BITS/FLASH_BEATS-1:0]   words;
  } line_u;

  // one queued line request
  typedef struct packed {
    logic                 op;        // 0 read, 1 write
    logic                 is_flash;
    logic [ADDR_BITS-1:0] addr;      // aligned
    line_u                wdata;
  } line_req_t;

endpackage

// File: hdl/line_req_issuer.sv
/* request issuer: captures the cache strobe, decodes the flash region
   and aligns the line address */
`timescale 1ns/100ps

module line_req_issuer
  import cache_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,

  // cache side
  input  logic                 i_req,    // one-cycle strobe
  input  logic                 i_op,     // 0 read, 1 write
  input  logic [ADDR_BITS-1:0] i_addr,
  input  logic [LINE_BITS-1:0] i_wdata,

  // to the request queue
  output logic                 o_push,
  output line_req_t            o_req
);

  logic                 flash;
  logic [ADDR_BITS-1:0] aligned_addr;

  // region decode done once here, the engine only looks at is_flash
  assign flash = (i_addr[31:28] == FLASH_REGION);

  always_comb begin
    if (flash) begin
      aligned_addr = i_addr & ~ADDR_BITS'(4'h3);   // word aligned
    end else begin
      aligned_addr = i_addr & ~ADDR_BITS'(8'h3f);  // line aligned
    end
  end

  // push strobe follows i_req by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      o_push <= 1'b0;
    end else begin
      o_push <= i_req;
    end
  end

  // request payload, only loaded on a strobe
  always_ff @(posedge clk) begin
    if (i_req) begin
      o_req.op        <= i_op;
      o_req.is_flash  <= flash;
      o_req.addr      <= aligned_addr;
      o_req.wdata.raw <= i_wdata;
    end
  end

endmodule

// File: hdl/line_req_fifo.sv
/* four-entry circular request queue between issuer and transfer engine,
   with an early busy level for the cache side */
`timescale 1ns/100ps

module line_req_fifo
  import cache_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      i_push,
  input  line_req_t i_req,

  input  logic      i_pop,
  output line_req_t o_req,        // head entry
  output logic      o_not_empty,
  output logic      o_busy
);

  line_req_t                       mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH):0]     count;
  logic                            full;
  logic                            do_push;
  logic                            do_pop;

  assign full        = (count == FIFO_DEPTH);
  assign o_not_empty = (count != 0);
  // one slot kept back for a request still in the issuer
  assign o_busy      = (count >= FIFO_DEPTH - 1);

  assign do_push = i_push && !full;
  assign do_pop  = i_pop && o_not_empty;

  assign o_req = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      unique case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/cache_axi.sv
/* transfer engine: runs one 512-bit beat for main memory or sixteen word beats
   for flash, assembles read lines and acks each request */
`timescale 1ns/100ps

module cache_axi
  import cache_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,

  // request queue
  input  line_req_t            i_req,
  input  logic                 i_not_empty,
  output logic                 o_pop,

  // cache completion
  output line_u                o_rdata,
  output logic                 o_ack,

  // memory bus
  input  logic                 i_bus_ready,
  input  logic [LINE_BITS-1:0] i_bus_rdata,
  output logic                 o_bus_valid,
  output logic                 o_bus_op,     // 0 read, 1 write
  output logic [ADDR_BITS-1:0] o_bus_addr,
  output logic [LINE_BITS-1:0] o_bus_wdata,
  output logic [2:0]           o_bus_size,
  output logic [7:0]           o_bus_blks
);

  logic                           hs;
  logic                           start;
  logic                           last_beat;
  logic                           op_q;
  logic                           flash_q;
  logic [$clog2(FLASH_BEATS)-1:0] beat_cnt;
  logic [$clog2(FLASH_BEATS)-1:0] next_beat;
  line_u                          wdata_q;    // line being written
  line_u                          line_buf;   // flash read assembly
  line_u                          fill;
  line_u                          rd_bus;
  line_u                          first_w;
  line_u                          next_w;

  assign hs        = o_bus_valid & i_bus_ready;
  assign start     = !o_bus_valid && i_not_empty;  // idle and work queued
  assign last_beat = !flash_q || (beat_cnt == FLASH_BEATS - 1);
  assign next_beat = beat_cnt + 1'b1;

  assign o_bus_op   = op_q;
  assign o_bus_size = flash_q ? SIZE_WORD : SIZE_DWORD;
  assign o_bus_blks = flash_q ? BLKS_SINGLE : BLKS_BURST;

  // flash data rides in the low word of the bus
  assign rd_bus.raw = i_bus_rdata;

  always_comb begin
    fill                 = line_buf;
    fill.words[beat_cnt] = rd_bus.words[0];
    first_w.raw          = '0;
    first_w.words[0]     = i_req.wdata.words[0];   // upper bits stay zero
    next_w.raw           = '0;
    next_w.words[0]      = wdata_q.words[next_beat];
  end

  // control: pop and valid rise together, ack with valid drop
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_valid <= 1'b0;
      o_pop       <= 1'b0;
      o_ack       <= 1'b0;
      op_q        <= 1'b0;
      flash_q     <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      o_pop <= 1'b0;
      o_ack <= 1'b0;
      if (start) begin
        o_bus_valid <= 1'b1;
        o_pop       <= 1'b1;
        op_q        <= i_req.op;
        flash_q     <= i_req.is_flash;
        beat_cnt    <= '0;
      end else if (hs) begin
        if (last_beat) begin
          o_bus_valid <= 1'b0;
          o_ack       <= 1'b1;
        end else begin
          beat_cnt <= next_beat;
        end
      end
    end
  end

  // bus payload and read assembly
  always_ff @(posedge clk) begin
    if (start) begin
      wdata_q     <= i_req.wdata;
      o_bus_addr  <= i_req.addr;
      o_bus_wdata <= i_req.is_flash ? first_w.raw : i_req.wdata.raw;
    end else if (hs) begin
      if (flash_q) begin
        line_buf <= fill;
        if (!last_beat) begin
          o_bus_addr  <= o_bus_addr + ADDR_BITS'(4);  // next word
          o_bus_wdata <= next_w.raw;
        end
      end
      // o_rdata only changes when a read finishes
      if (last_beat && !op_q) begin
        o_rdata <= flash_q ? fill : rd_bus;
      end
    end
  end

endmodule

// File: hdl/cache_line_port.sv
/* memory-side port of the data cache: issuer, request queue and transfer engine */
`timescale 1ns/100ps

module cache_line_port
  import cache_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,

  // cache side
  input  logic                 i_req,
  input  logic                 i_op,
  input  logic [ADDR_BITS-1:0] i_addr,
  input  logic [LINE_BITS-1:0] i_wdata,
  output logic                 o_busy,
  output logic                 o_ack,
  output line_u                o_rdata,

  // memory bus
  input  logic                 i_bus_ready,
  input  logic [LINE_BITS-1:0] i_bus_rdata,
  output logic                 o_bus_valid,
  output logic                 o_bus_op,
  output logic [ADDR_BITS-1:0] o_bus_addr,
  output logic [LINE_BITS-1:0] o_bus_wdata,
  output logic [2:0]           o_bus_size,
  output logic [7:0]           o_bus_blks
);

  logic      push;
  logic      pop;
  logic      not_empty;
  line_req_t issued_req;
  line_req_t head_req;

  line_req_issuer i_line_req_issuer (
    .clk     (clk),
    .rst     (rst),
    .i_req   (i_req),
    .i_op    (i_op),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_push  (push),
    .o_req   (issued_req)
  );

  line_req_fifo i_line_req_fifo (
    .clk         (clk),
    .rst         (rst),
    .i_push      (push),
    .i_req       (issued_req),
    .i_pop       (pop),
    .o_req       (head_req),
    .o_not_empty (not_empty),
    .o_busy      (o_busy)
  );

  cache_axi i_cache_axi (
    .clk         (clk),
    .rst         (rst),
    .i_req       (head_req),
    .i_not_empty (not_empty),
    .o_pop       (pop),
    .o_rdata     (o_rdata),
    .o_ack       (o_ack),
    .i_bus_ready (i_bus_ready),
    .i_bus_rdata (i_bus_rdata),
    .o_bus_valid (o_bus_valid),
    .o_bus_op    (o_bus_op),
    .o_bus_addr  (o_bus_addr),
    .o_bus_wdata (o_bus_wdata),
    .o_bus_size  (o_bus_size),
    .o_bus_blks  (o_bus_blks)
  );

endmodule

// File: verification/clk_gen.sv
/* testbench clock (100 ns period) and synchronous reset held for 16 cycles */
`timescale 1ns/100ps

module clk_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_NS     = 50;
  localparam int RST_CYCLES  = 16;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);  // release away from the sampling edge
    o_rst = 1'b0;
  end

endmodule

// File: verification/cache_line_port_properties.sv
/* bound assertions on the transfer engine: stall stability, ack pulse width,
   size and block count pairing */
`timescale 1ns/100ps

module cache_line_port_properties
  import cache_bus_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 i_valid,
  input logic                 i_ready,
  input logic                 i_op,
  input logic [ADDR_BITS-1:0] i_addr,
  input logic [LINE_BITS-1:0] i_wdata,
  input logic [2:0]           i_size,
  input logic [7:0]           i_blks,
  input logic                 i_ack
);

  int fail_count = 0;  // failed assertions so far

  // an offered beat stays put until ready
  property hold_while_stalled;
    @(posedge clk) disable iff (rst)
      (i_valid && !i_ready) |=> (i_valid && $stable(i_op) && $stable(i_addr) &&
                                 $stable(i_wdata) && $stable(i_size) && $stable(i_blks));
  endproperty

  a_hold: assert property (hold_while_stalled)
    else begin
      fail_count++;
      $error("bus request changed or dropped while ready was low");
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) i_ack |=> !i_ack)
    else begin
      fail_count++;
      $error("ack held for more than one cycle");
    end

  // 512-bit burst or single word, nothing in between
  a_size_blks: assert property (@(posedge clk) disable iff (rst)
    i_valid |-> ((i_size == SIZE_DWORD && i_blks == BLKS_BURST) ||
                 (i_size == SIZE_WORD && i_blks == BLKS_SINGLE)))
    else begin
      fail_count++;
      $error("bus size %0d does not match block count %0d", i_size, i_blks);
    end

endmodule

// File: verification/tb_cache_line_port.sv
/* testbench for the cache line port: bus memory model, request stimulus,
   reference line function, completion checker and watchdog */
`timescale 1ns/100ps

module tb_cache_line_port;
  import cache_bus_pkg::*;

  localparam int N_BURST      = 20;
  localparam int N_REQ        = 4 + N_BURST;           // directed plus burst
  localparam int CLK_NS       = 100;
  localparam int LIMIT_CYCLES = N_REQ * 16 * 5 + 200;  // margin covers reset and drain

  typedef struct packed {
    logic                 op;
    logic [ADDR_BITS-1:0] addr;
    logic [LINE_BITS-1:0] wdata;
    logic [2:0]           size;
    logic [7:0]           blks;
  } beat_t;

  logic                 clk;
  logic                 rst;
  logic                 i_req;
  logic                 i_op;
  logic [ADDR_BITS-1:0] i_addr;
  logic [LINE_BITS-1:0] i_wdata;
  logic                 o_busy;
  logic                 o_ack;
  line_u                o_rdata;
  logic                 bus_ready;
  logic [LINE_BITS-1:0] bus_rdata;
  logic                 bus_valid;
  logic                 bus_op;
  logic [ADDR_BITS-1:0] bus_addr;
  logic [LINE_BITS-1:0] bus_wdata;
  logic [2:0]           bus_size;
  logic [7:0]           bus_blks;

  line_req_t exp_q[$];   // issued, not yet acked
  beat_t     beat_q[$];  // beats of the request in flight
  line_u     last_rd;
  int        errors;
  int        tests_done;
  int        tests_failed;
  int        delay;
  logic      armed;

  clk_gen i_clk_gen (.o_clk(clk), .o_rst(rst));

  cache_line_port i_cache_line_port (
    .clk(clk), .rst(rst), .i_req(i_req), .i_op(i_op), .i_addr(i_addr),
    .i_wdata(i_wdata), .o_busy(o_busy), .o_ack(o_ack), .o_rdata(o_rdata),
    .i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata), .o_bus_valid(bus_valid),
    .o_bus_op(bus_op), .o_bus_addr(bus_addr), .o_bus_wdata(bus_wdata),
    .o_bus_size(bus_size), .o_bus_blks(bus_blks)
  );

  bind cache_axi cache_line_port_properties i_properties (
    .clk(clk), .rst(rst), .i_valid(o_bus_valid), .i_ready(i_bus_ready),
    .i_op(o_bus_op), .i_addr(o_bus_addr), .i_wdata(o_bus_wdata),
    .i_size(o_bus_size), .i_blks(o_bus_blks), .i_ack(o_ack)
  );

  function automatic logic is_flash_addr(input logic [ADDR_BITS-1:0] addr);
    return addr[31:28] == 4'h3;
  endfunction

  function automatic logic [ADDR_BITS-1:0] aligned_addr(input logic [ADDR_BITS-1:0] addr);
    if (is_flash_addr(addr)) begin
      return {addr[63:2], 2'b00};
    end
    return {addr[63:6], 6'b000000};
  endfunction

  // memory contents, every address bit matters
  function automatic logic [31:0] model_word(input logic [ADDR_BITS-1:0] addr);
    return (addr[31:0] * 32'h9e3779b1) ^ addr[63:32] ^ 32'h0badf00d;
  endfunction

  function automatic line_u memory_line(input logic [ADDR_BITS-1:0] addr);
    line_u line;
    for (int n = 0; n < FLASH_BEATS; n++) begin
      line.words[n] = model_word(addr + 64'(4 * n));
    end
    return line;
  endfunction

  // reference: the line the cache should get back for a read request
  function automatic line_u expected_line(input logic [ADDR_BITS-1:0] addr);
    return memory_line(aligned_addr(addr));
  endfunction

  function automatic logic [LINE_BITS-1:0] random_line();
    line_u line;
    for (int n = 0; n < FLASH_BEATS; n++) begin
      line.words[n] = $urandom();
    end
    return line.raw;
  endfunction

  task automatic check_value(input string name, input logic [LINE_BITS-1:0] got,
                             input logic [LINE_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] test %0d %s: got %h expected %h", tests_done, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_completion();
    line_req_t            req;
    beat_t                beat;
    logic [ADDR_BITS-1:0] base;
    line_u                exp_line;
    int                   n_beats;
    int                   errs_before;
    if (exp_q.size() == 0) begin
      $display("ack seen with no request outstanding");
      errors++;
      return;
    end
    req = exp_q.pop_front();
    errs_before = errors;
    base = aligned_addr(req.addr);
    n_beats = req.is_flash ? 16 : 1;
    if (beat_q.size() != n_beats) begin
      $display("test %0d: expected %0d bus beats, saw %0d", tests_done, n_beats, beat_q.size());
      errors++;
    end else begin
      for (int n = 0; n < n_beats; n++) begin
        beat = beat_q[n];
        check_value("o_bus_op", 512'(beat.op), 512'(req.op));
        check_value("o_bus_addr", 512'(beat.addr), 512'(base + 64'(4 * n)));
        check_value("o_bus_size", 512'(beat.size), req.is_flash ? 512'(2) : 512'(3));
        check_value("o_bus_blks", 512'(beat.blks), req.is_flash ? 512'(0) : 512'(7));
        if (req.op && req.is_flash) begin
          check_value("o_bus_wdata", beat.wdata, 512'(req.wdata.words[n]));
        end else if (req.op) begin
          check_value("o_bus_wdata", beat.wdata, req.wdata.raw);
        end
      end
    end
    beat_q.delete();
    if (req.op) begin
      check_value("o_rdata", o_rdata.raw, last_rd.raw);  // untouched by writes
    end else begin
      exp_line = expected_line(req.addr);
      check_value("o_rdata", o_rdata.raw, exp_line.raw);
      last_rd = exp_line;
    end
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %0d: %s %s at %h %s", tests_done, req.op ? "write" : "read",
             req.is_flash ? "flash" : "memory", req.addr,
             (errors == errs_before) ? "ok" : "mismatch");
    tests_done++;
  endtask

  // memory model, ready after 0 to 3 idle cycles per beat
  always @(negedge clk) begin
    if (rst) begin
      bus_ready = 1'b0;
      armed     = 1'b0;
    end else begin
      bus_ready = 1'b0;
      if (bus_valid) begin
        if (!armed) begin
          delay = $urandom_range(0, 3);
          armed = 1'b1;
        end
        if (delay == 0) begin
          beat_q.push_back({bus_op, bus_addr, bus_wdata, bus_size, bus_blks});
          if (bus_size == 3'd2) begin
            bus_rdata = {{15{32'hc3c35a5a}}, model_word(bus_addr)};  // junk above low word
          end else begin
            bus_rdata = memory_line(bus_addr);
          end
          bus_ready = 1'b1;
          armed     = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && o_ack) begin
      check_completion();
    end
  end

  task automatic issue(input logic op, input logic [ADDR_BITS-1:0] addr,
                       input logic [LINE_BITS-1:0] wdata);
    line_req_t req;
    while (o_busy) @(negedge clk);
    i_req   = 1'b1;
    i_op    = op;
    i_addr  = addr;
    i_wdata = wdata;
    req.op        = op;
    req.is_flash  = is_flash_addr(addr);
    req.addr      = addr;
    req.wdata.raw = wdata;
    exp_q.push_back(req);
    @(negedge clk);
    i_req = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  initial begin
    #(LIMIT_CYCLES * CLK_NS);
    $display("timeout: %0d requests still outstanding after %0d cycles", exp_q.size(),
             LIMIT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic                 op;
    logic [ADDR_BITS-1:0] addr;
    int                   assert_fails;
    void'($urandom(83555));
    i_req = 1'b0;
    i_op = 1'b0;
    i_addr = '0;
    i_wdata = '0;
    bus_ready = 1'b0;
    bus_rdata = '0;
    armed = 1'b0;
    delay = 0;
    errors = 0;
    tests_done = 0;
    tests_failed = 0;
    @(negedge clk);
    while (rst) @(negedge clk);
    if (o_ack !== 1'b0) begin
      $display("[FAIL] after reset o_ack: got %h expected 0", o_ack);
      errors++;
    end
    if (bus_valid !== 1'b0) begin
      $display("[FAIL] after reset o_bus_valid: got %h expected 0", bus_valid);
      errors++;
    end
    if (o_busy !== 1'b0) begin
      $display("[FAIL] after reset o_busy: got %h expected 0", o_busy);
      errors++;
    end
    // one of each kind, drained one at a time
    issue(1'b0, 64'h0000_0001_8000_1234, '0);
    wait_idle();
    issue(1'b0, 64'h0000_0000_3000_0106, '0);
    wait_idle();
    issue(1'b1, 64'h0000_0000_0040_007f, random_line());
    wait_idle();
    issue(1'b1, 64'h0000_0000_3abc_def3, random_line());
    wait_idle();
    // back to back, both regions and both directions
    for (int k = 0; k < N_BURST; k++) begin
      op   = 1'($urandom_range(0, 1));
      addr = {$urandom(), $urandom()};
      if ($urandom_range(0, 1) == 1) begin
        addr[31:28] = 4'h3;
      end else if (addr[31:28] == 4'h3) begin
        addr[31:28] = 4'h8;
      end
      issue(op, addr, random_line());
    end
    wait_idle();
    repeat (4) @(negedge clk);
    assert_fails = i_cache_line_port.i_cache_axi.i_properties.fail_count;
    if (assert_fails != 0) begin
      $display("bound bus assertions failed %0d times", assert_fails);
      errors += assert_fails;
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_done,
             tests_done - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_done == N_REQ) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
hdl/cache_bus_pkg.sv
hdl/line_req_issuer.sv
hdl/line_req_fifo.sv
hdl/cache_axi.sv
hdl/cache_line_port.sv
verification/clk_gen.sv
verification/cache_line_port_properties.sv
verification/tb_cache_line_port.sv

// File: Makefile
SIM  = obj_dir/Vtb_cache_line_port
SRCS = $(shell cat sim.f)

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_line_port -f sim.f

clean:
	rm -rf obj_dir sim.log
